/* dv/renkon_tb.sv */
`timescale 1ns/1ps

module renkon_tb;

  localparam int DW = renkon_cfg_pkg::DWIDTH;
  localparam int IW = renkon_cfg_pkg::IMGSIZE;
  localparam int NW = renkon_cfg_pkg::NETSIZE;
  localparam int LW = renkon_cfg_pkg::LWIDTH;
  localparam int ACK_LIMIT  = 20;
  localparam int DONE_LIMIT = 5000;

  logic                       clk;
  logic                       xrst;
  logic                       req;
  logic                       ack;
  renkon_op_pkg::core_state_t core_state;
  logic [IW-1:0]              in_offset;
  logic [IW-1:0]              out_offset;
  logic [NW-1:0]              net_offset;
  logic [LW-1:0]              total_in;
  logic [LW-1:0]              total_out;
  logic [LW-1:0]              img_size;
  logic                       img_we;
  logic [IW-1:0]              img_addr;
  logic [DW-1:0]              img_wdata;
  logic                       net_we;
  logic [NW-1:0]              net_addr;
  logic [DW-1:0]              net_wdata;
  logic [IW-1:0]              rd_addr;
  logic [DW-1:0]              rd_data;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     failed_tests = 0;
  int     test_err = 0;

  // job record from the vectors file
  string                j_name;
  logic [IW-1:0]        j_in;
  logic [IW-1:0]        j_out;
  logic [NW-1:0]        j_net;
  logic [LW-1:0]        j_tin;
  logic [LW-1:0]        j_tout;
  logic [LW-1:0]        j_isize;
  int                   j_hold;
  logic signed [DW-1:0] exp_q[$];
  logic [IW-1:0]        keep_addr[$];
  logic signed [DW-1:0] keep_val[$];

  renkon_top #(.FRAC_BITS(8)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

//======================================================================
// checks and reporting
//======================================================================

  task automatic check_data(input string name, input logic signed [DW-1:0] got,
                            input logic signed [DW-1:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      test_err++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_state(input string name, input renkon_op_pkg::core_state_t got,
                             input renkon_op_pkg::core_state_t want);
    checks++;
    if (got !== want) begin
      errors++;
      test_err++;
      $display("ERROR %0t %s got %0d (%s) expected %0d (%s)", $time, name,
               got, got.name(), want, want.name());
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      test_err++;
      $display("ERROR %0t %s got %b expected %b", $time, name, got, want);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("%0t: %s", $time, what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (test_err != 0) begin
      failed_tests++;
    end
    $display("test %-12s %s (%0d errors)", name, test_err == 0 ? "ok" : "mismatch", test_err);
    test_err = 0;
  endtask

//======================================================================
// host access
//======================================================================

  task automatic write_word(input logic to_net, input logic [IW-1:0] addr,
                            input logic [DW-1:0] data);
    @(negedge clk);
    img_we    = !to_net;
    net_we    = to_net;
    img_addr  = addr;
    net_addr  = addr[NW-1:0];
    img_wdata = data;
    net_wdata = data;
    @(negedge clk);
    img_we = 1'b0;
    net_we = 1'b0;
  endtask

  // registered read data arrives one cycle after the address
  task automatic read_out(input logic [IW-1:0] addr, output logic signed [DW-1:0] data);
    @(negedge clk);
    rd_addr = addr;
    @(negedge clk);
    data = rd_data;
  endtask

  // expected phase order with one round per output map
  function automatic renkon_op_pkg::core_state_t next_phase(
      input renkon_op_pkg::core_state_t prev, input int maps);
    case (prev)
      renkon_op_pkg::S_NETWORK: return renkon_op_pkg::S_INPUT;
      renkon_op_pkg::S_INPUT:   return renkon_op_pkg::S_OUTPUT;
      renkon_op_pkg::S_OUTPUT:
        return (maps < j_tout) ? renkon_op_pkg::S_NETWORK : renkon_op_pkg::S_WAIT;
      default:                  return renkon_op_pkg::S_NETWORK;
    endcase
  endfunction

  task automatic run_job();
    int n;
    int maps;
    renkon_op_pkg::core_state_t prev;
    @(negedge clk);
    in_offset  = j_in;
    out_offset = j_out;
    net_offset = j_net;
    total_in   = j_tin;
    total_out  = j_tout;
    img_size   = j_isize;
    req        = 1'b1;
    n = 0;
    while (ack !== 1'b0 && n < ACK_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (ack !== 1'b0) begin
      timeout_fail("ack did not fall after the req edge");
    end
    maps = 0;
    prev = renkon_op_pkg::S_WAIT;
    n = 0;
    // each phase lasts at least one cycle and shows in a sample
    while (ack !== 1'b1 && n < DONE_LIMIT) begin
      if (core_state !== prev) begin
        check_state("core_state", core_state, next_phase(prev, maps));
        if (core_state == renkon_op_pkg::S_NETWORK) begin
          maps++;
        end
        prev = core_state;
      end
      @(negedge clk);
      n++;
    end
    if (ack !== 1'b1) begin
      timeout_fail("ack did not rise within the job time limit");
    end
    check_state("core_state", core_state, next_phase(prev, maps));
    // req stays high and makes no new edge
    repeat (j_hold) begin
      @(negedge clk);
      check_flag("ack", ack, 1'b1);
      check_state("core_state", core_state, renkon_op_pkg::S_WAIT);
    end
    req = 1'b0;
  endtask

  task automatic check_results(input logic [IW-1:0] base);
    logic signed [DW-1:0] v;
    logic [IW-1:0]        a;
    foreach (exp_q[k]) begin
      a = base + IW'(k);
      read_out(a, v);
      check_data($sformatf("rd_data[%h]", a), v, exp_q[k]);
    end
    foreach (keep_addr[k]) begin
      read_out(keep_addr[k], v);
      check_data($sformatf("rd_data[%h] outside job", keep_addr[k]), v, keep_val[k]);
    end
  endtask

//======================================================================
// vectors file
//======================================================================

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != "\n" && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic load_section(input int fd, input logic to_net);
    int            rc;
    int            n;
    logic [IW-1:0] a;
    logic [DW-1:0] w;
    rc = $fscanf(fd, "%h %d", a, n);
    for (int k = 0; k < n; k++) begin
      rc = $fscanf(fd, "%h", w);
      write_word(to_net, a + IW'(k), w);
    end
  endtask

  task automatic run_vectors(input int fd);
    string                tok;
    int                   rc;
    int                   n;
    int                   gap;
    logic [IW-1:0]        a;
    logic signed [DW-1:0] v;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        skip_line(fd);
      end else if (tok == "job") begin
        rc = $fscanf(fd, "%s %h %h %h %h %h %h %d", j_name, j_in, j_out, j_net,
                     j_tin, j_tout, j_isize, j_hold);
        exp_q.delete();
        keep_addr.delete();
        keep_val.delete();
      end else if (tok == "img") begin
        load_section(fd, 1'b0);
      end else if (tok == "net") begin
        load_section(fd, 1'b1);
      end else if (tok == "keep") begin
        rc = $fscanf(fd, "%d", n);
        repeat (n) begin
          rc = $fscanf(fd, "%h", a);
          read_out(a, v);
          keep_addr.push_back(a);
          keep_val.push_back(v);
        end
      end else if (tok == "exp") begin
        rc = $fscanf(fd, "%h %d", a, n);
        repeat (n) begin
          rc = $fscanf(fd, "%h", v);
          exp_q.push_back(v);
        end
        gap = {$random(seed)} % 16;
        repeat (gap) @(negedge clk);
        run_job();
        check_results(a);
        finish_test(j_name);
      end else begin
        $display("unknown keyword %s in the vectors file", tok);
        errors++;
      end
    end
  endtask

  initial begin
    int fd;
    seed       = 32'h4606;
    xrst       = 1'b0;
    req        = 1'b0;
    in_offset  = '0;
    out_offset = '0;
    net_offset = '0;
    total_in   = '0;
    total_out  = '0;
    img_size   = '0;
    img_we     = 1'b0;
    img_addr   = '0;
    img_wdata  = '0;
    net_we     = 1'b0;
    net_addr   = '0;
    net_wdata  = '0;
    rd_addr    = '0;
    repeat (8) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);
    check_flag("ack", ack, 1'b1);
    check_state("core_state", core_state, renkon_op_pkg::S_WAIT);
    finish_test("reset");
    fd = $fopen("dv/renkon_vectors.txt", "r");
    if (fd == 0) begin
      $display("vectors file dv/renkon_vectors.txt could not be opened");
      errors++;
    end else begin
      run_vectors(fd);
      $fclose(fd);
    end
    $display("tests %0d failed %0d checks %0d errors %0d", tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* dv/renkon_vectors.txt */
# job name in_off out_off net_off total_in total_out img_size hold_cycles (hex, hold decimal)
# img/net/exp base count words, keep count addrs; words are 16 bit hex, weights Q8
# single map, one input, floor on the shift
job single 000 000 00 1 1 2 0
img 000 4 0010 0020 fff0 0005
net 00 2 0200 0080
exp 000 4 0020 0040 ffe0 000a
# three inputs, two outputs, all offsets non-zero
job multi 040 004 10 3 2 2 0
img 040 12 0008 0010 0020 0004 0004 0008 fffc 0010 0002 0006 0010 fff8
net 10 8 0100 0080 ff00 0100 0000 0200 0040 ff00
keep 2 003 00c
exp 004 8 0009 000f 000f 0015 0007 0010 fffb 001d
# saturation at both ends, plus values just inside
job saturate 080 020 20 2 1 2 0
img 080 8 7fff 8000 0100 ff00 7fff 8000 0000 0000
net 20 3 7fff 7fff 0000
exp 020 4 7fff 8000 7fff 8001
# req held high after the job ends
job phases_hold 0a0 030 30 2 2 1 20
img 0a0 2 0300 0100
net 30 6 0100 0100 0000 0080 ff80 0000
exp 030 2 0400 0100
# back to back on the memories of the multi job, new configuration each time
job b2b_first 040 040 10 3 1 2 0
exp 040 4 0009 000f 000f 0015
job b2b_second 044 050 14 2 1 2 0
exp 050 4 0004 000c 0020 fff0

/* hdl/mac_bus.sv */
`timescale 1ns/1ps

interface mac_bus;

  logic                               load;
  logic                               bias;
  logic                               start;
  logic                               valid;
  logic                               stop;
  logic                               tail;
  logic [renkon_cfg_pkg::SELW-1:0]    sel;

  modport master (output load, bias, start, valid, stop, tail, sel);

  modport slave  (input  load, bias, start, valid, stop, tail, sel);

endinterface

/* hdl/renkon_cfg_pkg.sv */
package renkon_cfg_pkg;

  // signed pixel and weight word
  localparam int DWIDTH  = 16;

  // accumulator for the weighted sum
  localparam int AWIDTH  = 32;

  // counts and sizes from the host
  localparam int LWIDTH  = 8;

  // address widths of image and network memories
  localparam int IMGSIZE = 10;
  localparam int NETSIZE = 8;

  // weight registers in the mac
  localparam int MAX_IN  = 8;
  localparam int SELW    = 3;

endpackage

/* hdl/renkon_ctrl.sv */
`timescale 1ns/1ps

module renkon_ctrl (
  input  logic                                  clk,
  input  logic                                  xrst,
  input  logic                                  req,
  input  logic [renkon_cfg_pkg::IMGSIZE-1:0]    in_offset,
  input  logic [renkon_cfg_pkg::NETSIZE-1:0]    net_offset,
  input  logic [renkon_cfg_pkg::LWIDTH-1:0]     total_in,
  input  logic [renkon_cfg_pkg::LWIDTH-1:0]     total_out,
  input  logic [renkon_cfg_pkg::LWIDTH-1:0]     img_size,
  input  logic                                  map_done,
  output logic                                  ack,
  output renkon_op_pkg::core_state_t            core_state,
  output logic [renkon_cfg_pkg::IMGSIZE-1:0]    img_raddr,
  output logic [renkon_cfg_pkg::NETSIZE-1:0]    net_raddr,
  output logic                                  job_start,
  mac_bus.master                                bus
);

  localparam int LW = renkon_cfg_pkg::LWIDTH;
  localparam int IW = renkon_cfg_pkg::IMGSIZE;
  localparam int NW = renkon_cfg_pkg::NETSIZE;
  localparam int SW = renkon_cfg_pkg::SELW;

  renkon_op_pkg::core_state_t    state;
  renkon_op_pkg::weight_phase_t  wphase;

  logic          req_r;
  logic          req_edge;
  logic [LW-1:0] total_in_r;
  logic [LW-1:0] total_out_r;
  logic [LW-1:0] count_in;
  logic [LW-1:0] count_out;
  logic [IW-1:0] in_offset_r;
  logic [IW-1:0] npix_r;
  logic [IW-1:0] pix;
  logic [IW-1:0] pix_base;
  logic [IW-1:0] img_ptr;
  logic [NW-1:0] net_ptr;
  logic          last_in;
  logic          last_pix;
  logic          last_out;
  logic          network_end;
  logic          input_end;
  logic          load_r;
  logic          bias_r;
  logic          start_r;
  logic          valid_r;
  logic          stop_r;
  logic          tail_r;
  logic [SW-1:0] sel_r;

//======================================================================
// job start and phase sequencing
//======================================================================

  assign req_edge    = req && !req_r;
  assign job_start   = req_edge && state == renkon_op_pkg::S_WAIT;
  assign last_in     = count_in == total_in_r - 1'b1;
  assign last_pix    = pix == npix_r - 1'b1;
  assign last_out    = count_out == total_out_r - 1'b1;
  assign network_end = state == renkon_op_pkg::S_NETWORK
                    && wphase == renkon_op_pkg::S_W_BIAS;
  assign input_end   = state == renkon_op_pkg::S_INPUT && last_in && last_pix;
  assign core_state  = state;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_r <= 1'b0;
    end else begin
      req_r <= req;
    end
  end

  // job configuration
  always_ff @(posedge clk) begin
    if (job_start) begin
      in_offset_r <= in_offset;
      total_in_r  <= total_in;
      total_out_r <= total_out;
      npix_r      <= IW'(img_size) * IW'(img_size);
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= renkon_op_pkg::S_WAIT;
      count_out <= '0;
      ack       <= 1'b1;
    end else begin
      case (state)
        renkon_op_pkg::S_WAIT: begin
          if (job_start) begin
            state     <= renkon_op_pkg::S_NETWORK;
            count_out <= '0;
            ack       <= 1'b0;
          end
        end
        renkon_op_pkg::S_NETWORK: begin
          if (network_end) begin
            state <= renkon_op_pkg::S_INPUT;
          end
        end
        renkon_op_pkg::S_INPUT: begin
          if (input_end) begin
            state <= renkon_op_pkg::S_OUTPUT;
          end
        end
        renkon_op_pkg::S_OUTPUT: begin
          // wait for the writer to store the tail pixel
          if (map_done) begin
            if (last_out) begin
              state <= renkon_op_pkg::S_WAIT;
              ack   <= 1'b1;
            end else begin
              state     <= renkon_op_pkg::S_NETWORK;
              count_out <= count_out + 1'b1;
            end
          end
        end
        default: state <= renkon_op_pkg::S_WAIT;
      endcase
    end
  end

//======================================================================
// network fetch
//======================================================================

  // weights first and then one bias word
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wphase   <= renkon_op_pkg::S_W_WEIGHT;
      count_in <= '0;
    end else if (state == renkon_op_pkg::S_NETWORK) begin
      case (wphase)
        renkon_op_pkg::S_W_WEIGHT: begin
          if (last_in) begin
            wphase   <= renkon_op_pkg::S_W_BIAS;
            count_in <= '0;
          end else begin
            count_in <= count_in + 1'b1;
          end
        end
        default: wphase <= renkon_op_pkg::S_W_WEIGHT;
      endcase
    end else if (state == renkon_op_pkg::S_INPUT) begin
      count_in <= last_in ? '0 : count_in + 1'b1;
    end else begin
      count_in <= '0;
    end
  end

  // network words are contiguous over all maps
  always_ff @(posedge clk) begin
    if (!xrst) begin
      net_ptr <= '0;
    end else if (job_start) begin
      net_ptr <= net_offset;
    end else if (state == renkon_op_pkg::S_NETWORK) begin
      net_ptr <= net_ptr + 1'b1;
    end
  end

  assign net_raddr = net_ptr;

//======================================================================
// input stream
//======================================================================

  // input maps vary fastest with a stride of one map
  always_ff @(posedge clk) begin
    if (!xrst) begin
      pix      <= '0;
      pix_base <= '0;
      img_ptr  <= '0;
    end else if (network_end) begin
      pix      <= '0;
      pix_base <= in_offset_r;
      img_ptr  <= in_offset_r;
    end else if (state == renkon_op_pkg::S_INPUT) begin
      if (last_in) begin
        pix      <= pix + 1'b1;
        pix_base <= pix_base + 1'b1;
        img_ptr  <= pix_base + 1'b1;
      end else begin
        img_ptr  <= img_ptr + npix_r;
      end
    end
  end

  assign img_raddr = img_ptr;

  // marks delayed to meet the memory read data
  always_ff @(posedge clk) begin
    if (!xrst) begin
      load_r  <= 1'b0;
      bias_r  <= 1'b0;
      valid_r <= 1'b0;
      start_r <= 1'b0;
      stop_r  <= 1'b0;
      tail_r  <= 1'b0;
      sel_r   <= '0;
    end else begin
      load_r  <= state == renkon_op_pkg::S_NETWORK
              && wphase == renkon_op_pkg::S_W_WEIGHT;
      bias_r  <= network_end;
      valid_r <= state == renkon_op_pkg::S_INPUT;
      start_r <= state == renkon_op_pkg::S_INPUT && count_in == '0;
      stop_r  <= state == renkon_op_pkg::S_INPUT && last_in;
      tail_r  <= input_end;
      sel_r   <= count_in[SW-1:0];
    end
  end

  assign bus.load  = load_r;
  assign bus.bias  = bias_r;
  assign bus.valid = valid_r;
  assign bus.start = start_r;
  assign bus.stop  = stop_r;
  assign bus.tail  = tail_r;
  assign bus.sel   = sel_r;

  // the writer only finishes a map while the core drains it
  a_done_in_output: assert property (@(posedge clk) disable iff (!xrst)
    map_done |-> state == renkon_op_pkg::S_OUTPUT);

  a_job_config: assert property (@(posedge clk) disable iff (!xrst)
    job_start |-> total_in != '0 && total_in <= renkon_cfg_pkg::MAX_IN
              && total_out != '0 && img_size != '0);

endmodule

/* hdl/renkon_mac.sv */
`timescale 1ns/1ps

module renkon_mac #(
  parameter int FRAC_BITS = 8
) (
  input  logic                                       clk,
  input  logic                                       xrst,
  mac_bus.slave                                      bus,
  input  logic signed [renkon_cfg_pkg::DWIDTH-1:0]   pix,
  input  logic signed [renkon_cfg_pkg::DWIDTH-1:0]   net,
  output logic                                       res_valid,
  output logic signed [renkon_cfg_pkg::DWIDTH-1:0]   res_data,
  output logic                                       res_tail
);

  localparam int DW = renkon_cfg_pkg::DWIDTH;
  localparam int AW = renkon_cfg_pkg::AWIDTH;
  localparam logic signed [AW-1:0] SAT_MAX = 2**(DW-1) - 1;
  localparam logic signed [AW-1:0] SAT_MIN = -(2**(DW-1));

  logic signed [DW-1:0] wreg [renkon_cfg_pkg::MAX_IN];
  logic signed [DW-1:0] breg;
  logic signed [AW-1:0] prod;
  logic signed [AW-1:0] acc;
  logic signed [AW-1:0] partial;
  logic signed [AW-1:0] sum;
  logic signed [AW-1:0] scaled;
  logic                 valid_d;
  logic                 start_d;
  logic                 stop_d;
  logic                 tail_d;

  always_ff @(posedge clk) begin
    if (bus.load) begin
      wreg[bus.sel] <= net;
    end
    if (bus.bias) begin
      breg <= net;
    end
  end

  // stage 1 product
  always_ff @(posedge clk) begin
    if (bus.valid) begin
      prod <= pix * wreg[bus.sel];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      valid_d <= 1'b0;
      start_d <= 1'b0;
      stop_d  <= 1'b0;
      tail_d  <= 1'b0;
    end else begin
      valid_d <= bus.valid;
      start_d <= bus.start;
      stop_d  <= bus.stop;
      tail_d  <= bus.tail;
    end
  end

  // stage 2 accumulates and adds the bias only on the result path
  assign partial = (start_d ? '0 : acc) + prod;
  assign sum     = partial + AW'(breg);
  assign scaled  = sum >>> FRAC_BITS;

  always_ff @(posedge clk) begin
    if (valid_d) begin
      acc <= partial;
    end
    if (valid_d && stop_d) begin
      if (scaled > SAT_MAX) begin
        res_data <= SAT_MAX[DW-1:0];
      end else if (scaled < SAT_MIN) begin
        res_data <= SAT_MIN[DW-1:0];
      end else begin
        res_data <= scaled[DW-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      res_valid <= 1'b0;
      res_tail  <= 1'b0;
    end else begin
      res_valid <= valid_d && stop_d;
      res_tail  <= valid_d && stop_d && tail_d;
    end
  end

  a_marks_valid: assert property (@(posedge clk) disable iff (!xrst)
    (bus.start || bus.stop) |-> bus.valid);

  // a weight load must not meet a pixel that reads the weight registers
  a_load_valid: assert property (@(posedge clk) disable iff (!xrst)
    !(bus.load && bus.valid));

endmodule

/* hdl/renkon_mem.sv */
`timescale 1ns/1ps

module renkon_mem #(
  parameter int AW    = 10,
  parameter int DW    = 16,
  parameter int DEPTH = 1024
) (
  input  logic          clk,
  input  logic          we,
  input  logic [AW-1:0] waddr,
  input  logic [DW-1:0] wdata,
  input  logic [AW-1:0] raddr,
  output logic [DW-1:0] rdata
);

  logic [DW-1:0] mem [DEPTH];

  // read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

/* hdl/renkon_op_pkg.sv */
package renkon_op_pkg;

  // main phases of the core with one round per output map
  typedef enum logic [1:0] {
    S_WAIT    = 2'd0,
    S_NETWORK = 2'd1,
    S_INPUT   = 2'd2,
    S_OUTPUT  = 2'd3
  } core_state_t;

  // sub phase while the network is fetched
  typedef enum logic {
    S_W_WEIGHT = 1'b0,
    S_W_BIAS   = 1'b1
  } weight_phase_t;

endpackage

/* hdl/renkon_top.sv */
`timescale 1ns/1ps

module renkon_top #(
  parameter int FRAC_BITS = 8
) (
  input  logic                                  clk,
  input  logic                                  xrst,
  input  logic                                  req,
  output logic                                  ack,
  output renkon_op_pkg::core_state_t            core_state,
  input  logic [renkon_cfg_pkg::IMGSIZE-1:0]    in_offset,
  input  logic [renkon_cfg_pkg::IMGSIZE-1:0]    out_offset,
  input  logic [renkon_cfg_pkg::NETSIZE-1:0]    net_offset,
  input  logic [renkon_cfg_pkg::LWIDTH-1:0]     total_in,
  input  logic [renkon_cfg_pkg::LWIDTH-1:0]     total_out,
  input  logic [renkon_cfg_pkg::LWIDTH-1:0]     img_size,
  input  logic                                  img_we,
  input  logic [renkon_cfg_pkg::IMGSIZE-1:0]    img_addr,
  input  logic [renkon_cfg_pkg::DWIDTH-1:0]     img_wdata,
  input  logic                                  net_we,
  input  logic [renkon_cfg_pkg::NETSIZE-1:0]    net_addr,
  input  logic [renkon_cfg_pkg::DWIDTH-1:0]     net_wdata,
  input  logic [renkon_cfg_pkg::IMGSIZE-1:0]    rd_addr,
  output logic [renkon_cfg_pkg::DWIDTH-1:0]     rd_data
);

  localparam int DW = renkon_cfg_pkg::DWIDTH;
  localparam int IW = renkon_cfg_pkg::IMGSIZE;
  localparam int NW = renkon_cfg_pkg::NETSIZE;

  logic          job_start;
  logic          map_done;
  logic [IW-1:0] img_raddr;
  logic [NW-1:0] net_raddr;
  logic [DW-1:0] img_rdata;
  logic [DW-1:0] net_rdata;
  logic          res_valid;
  logic [DW-1:0] res_data;
  logic          res_tail;
  logic          out_we;
  logic [IW-1:0] out_waddr;
  logic [DW-1:0] out_wdata;

  mac_bus bus ();

  renkon_mem #(.AW(IW), .DW(DW), .DEPTH(2**IW)) u_img (
    .clk, .we(img_we), .waddr(img_addr), .wdata(img_wdata),
    .raddr(img_raddr), .rdata(img_rdata)
  );

  renkon_mem #(.AW(NW), .DW(DW), .DEPTH(2**NW)) u_net (
    .clk, .we(net_we), .waddr(net_addr), .wdata(net_wdata),
    .raddr(net_raddr), .rdata(net_rdata)
  );

  renkon_mem #(.AW(IW), .DW(DW), .DEPTH(2**IW)) u_out (
    .clk, .we(out_we), .waddr(out_waddr), .wdata(out_wdata),
    .raddr(rd_addr), .rdata(rd_data)
  );

  renkon_ctrl u_ctrl (
    .clk, .xrst, .req, .in_offset, .net_offset, .total_in, .total_out,
    .img_size, .map_done, .ack, .core_state, .img_raddr, .net_raddr,
    .job_start, .bus(bus.master)
  );

  renkon_mac #(.FRAC_BITS(FRAC_BITS)) u_mac (
    .clk, .xrst, .bus(bus.slave), .pix(img_rdata), .net(net_rdata),
    .res_valid, .res_data, .res_tail
  );

  renkon_writeback u_wb (
    .clk, .xrst, .job_start, .out_offset, .res_valid, .res_data,
    .res_tail, .out_we, .out_waddr, .out_wdata, .map_done
  );

endmodule

/* hdl/renkon_writeback.sv */
`timescale 1ns/1ps

module renkon_writeback (
  input  logic                                       clk,
  input  logic                                       xrst,
  input  logic                                       job_start,
  input  logic [renkon_cfg_pkg::IMGSIZE-1:0]         out_offset,
  input  logic                                       res_valid,
  input  logic signed [renkon_cfg_pkg::DWIDTH-1:0]   res_data,
  input  logic                                       res_tail,
  output logic                                       out_we,
  output logic [renkon_cfg_pkg::IMGSIZE-1:0]         out_waddr,
  output logic [renkon_cfg_pkg::DWIDTH-1:0]          out_wdata,
  output logic                                       map_done
);

  logic [renkon_cfg_pkg::IMGSIZE-1:0] waddr;

  // one running address over all output maps
  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_we   <= 1'b0;
      map_done <= 1'b0;
      waddr    <= '0;
    end else begin
      out_we   <= res_valid;
      map_done <= res_valid && res_tail;
      if (job_start) begin
        waddr <= out_offset;
      end else if (out_we) begin
        waddr <= waddr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid) begin
      out_wdata <= res_data;
    end
  end

  assign out_waddr = waddr;

endmodule

/* renkon_top.f */
hdl/renkon_cfg_pkg.sv
hdl/renkon_op_pkg.sv
hdl/mac_bus.sv
hdl/renkon_mem.sv
hdl/renkon_ctrl.sv
hdl/renkon_mac.sv
hdl/renkon_writeback.sv
hdl/renkon_top.sv
dv/renkon_tb.sv
